/* tb/mcu_testdata.txt */
# op address data strobe expected (all hex)
# W write, R read, G drive pins, P expects {gpio_oe, gpio_output}, I expects irq_timer, N idle
W 00000000 11223344 f 00000000
W 00000004 aabbccdd f 00000000
W 00000008 deadbeef f 00000000
R 00000000 00000000 0 11223344
R 00000004 00000000 0 aabbccdd
W 00000000 000000ee 1 00000000
W 00000004 99000000 8 00000000
W 00000008 00005500 2 00000000
W 00000008 77660000 c 00000000
R 00000000 00000000 0 112233ee
R 00000004 00000000 0 99bbccdd
R 00000008 00000000 0 776655ef
W 000003fc cafef00d f 00000000
R 000003fc 00000000 0 cafef00d
W 000003fc 00ab00cd 5 00000000
R 000003fc 00000000 0 caabf0cd
W 40000000 12345678 f 00000000
R 40000000 00000000 0 00000000
R 00000400 00000000 0 00000000
R 00000004 00000000 0 99bbccdd
I 00000000 00000000 0 00000000
W 80010000 00000064 f 00000000
W 80010004 00003400 2 00000000
W 80010008 0000005f f 00000000
W 8001000c 00000000 f 00000000
R 80010000 00000000 0 00000064
R 80010004 00000000 0 00003400
R 80010008 00000000 0 0000005f
R 8001000c 00000000 0 00000000
R 80010010 00000000 0 00000000
I 00000000 00000000 0 00000000
W 80010004 00000000 f 00000000
W 80010010 00000001 1 00000000
N 00000000 00000000 0 00000000
I 00000000 00000000 0 00000001
W 8001000c 00000001 f 00000000
N 00000000 00000000 0 00000000
I 00000000 00000000 0 00000000
R 80010010 00000000 0 00000001
W 80020004 000000a5 1 00000000
W 80020008 0000003c 1 00000000
P 00000000 00000000 0 00003ca5
R 80020004 00000000 0 000000a5
R 80020008 00000000 0 0000003c
W 80020004 000000ff 2 00000000
P 00000000 00000000 0 00003ca5
G 00000000 0000005a 0 00000000
N 00000000 00000000 0 00000000
N 00000000 00000000 0 00000000
N 00000000 00000000 0 00000000
R 80020000 00000000 0 0000005a
R 8002001c 00000000 0 00000000

/* project.f */
source/mcu_pkg.sv
source/system_bus.sv
source/ram.sv
source/mtimer.sv
source/gpio.sv
source/mcu_subsystem.sv
tb/mcu_props.sv
tb/tb_mcu.sv

/* tb/tb_mcu.sv */
`default_nettype none

module tb_mcu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD    = 100;
  localparam int    RESET_CYCLES  = 4;
  localparam string TESTDATA_FILE = "tb/mcu_testdata.txt";

  // One line of the testdata file
  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] address;
    logic [31:0] data;
    logic [3:0]  strobe;
    logic [31:0] expected;
  } test_op_t;

  logic                           clock;
  logic                           arst_n;
  mcu_pkg::bus_req_t              bus_req;
  mcu_pkg::bus_rsp_t              bus_rsp;
  logic                           irq_timer;
  logic [mcu_pkg::GPIO_WIDTH-1:0] gpio_input;
  logic [mcu_pkg::GPIO_WIDTH-1:0] gpio_output;
  logic [mcu_pkg::GPIO_WIDTH-1:0] gpio_oe;

  test_op_t ops[$];
  int       line_count;
  int       mismatch_count;
  int       failure_count;
  logic     loaded;

  mcu_subsystem mcu_subsystem_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .irq_timer   (irq_timer),
    .gpio_input  (gpio_input),
    .gpio_output (gpio_output),
    .gpio_oe     (gpio_oe)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // ------------------------------------------------------------------
  // Stimulus file and request driving
  // ------------------------------------------------------------------

  task automatic load_testdata();
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  op_char;
    logic [31:0] address;
    logic [31:0] data;
    logic [3:0]  strobe;
    logic [31:0] expected;
    test_op_t    entry;
    fd = $fopen(TESTDATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the testdata file %s", TESTDATA_FILE);
      failure_count++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      line_count++;
      // Skip comments and blank lines
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      fields = $sscanf(line, "%c %h %h %h %h", op_char, address, data, strobe, expected);
      if (fields != 5) begin
        $display("Testdata line %0d could not be parsed", line_count);
        failure_count++;
      end else begin
        entry.op       = op_char;
        entry.address  = address;
        entry.data     = data;
        entry.strobe   = strobe;
        entry.expected = expected;
        ops.push_back(entry);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_op(input test_op_t entry);
    mcu_pkg::bus_req_t req;
    req               = '0;
    req.address       = entry.address;
    req.write_data    = entry.data;
    req.write_strobe  = entry.strobe;
    req.read_request  = (entry.op == "R");
    req.write_request = (entry.op == "W");
    bus_req <= req;
    if (entry.op == "G") begin
      gpio_input <= entry.data[mcu_pkg::GPIO_WIDTH-1:0];
    end
  endtask

  // Answer expected one cycle after the given operation
  function automatic mcu_pkg::bus_rsp_t expected_rsp(input test_op_t entry);
    mcu_pkg::bus_rsp_t rsp;
    rsp                = '0;
    rsp.read_response  = (entry.op == "R");
    rsp.write_response = (entry.op == "W");
    if (entry.op == "R") begin
      rsp.read_data = entry.expected;
    end
    return rsp;
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------

  task automatic check_rsp(
    input mcu_pkg::bus_rsp_t actual,
    input mcu_pkg::bus_rsp_t expected,
    input logic [31:0]       address
  );
    if (actual.read_response !== expected.read_response) begin
      failure_count++;
      if (expected.read_response) begin
        $display("No read response at %0d ns for address %h", $time, address);
      end else begin
        $display("Read response at %0d ns without a read request", $time);
      end
    end
    if (actual.write_response !== expected.write_response) begin
      failure_count++;
      if (expected.write_response) begin
        $display("No write response at %0d ns for address %h", $time, address);
      end else begin
        $display("Write response at %0d ns without a write request", $time);
      end
    end
    if (expected.read_response && actual.read_response === 1'b1 &&
        actual.read_data !== expected.read_data) begin
      mismatch_count++;
      $display("Mismatch at %0d ns: read of %h returned %h, expected %h",
               $time, address, actual.read_data, expected.read_data);
    end
  endtask

  task automatic check_gpio(
    input logic [mcu_pkg::GPIO_WIDTH-1:0] actual,
    input logic [mcu_pkg::GPIO_WIDTH-1:0] expected,
    input string                          pin_name
  );
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, pin_name, actual, expected);
    end
  endtask

  task automatic check_irq(input logic actual, input logic expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0d ns: irq_timer is %b, expected %b", $time, actual, expected);
    end
  endtask

  task automatic report_counts();
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, failure_count);
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  // Requests go out at a rising edge and answers are sampled at the next falling edge
  initial begin : run_tests
    test_op_t pending;
    test_op_t entry;
    clock          = 1'b0;
    arst_n         = 1'b0;
    bus_req        = '0;
    gpio_input     = '0;
    line_count     = 0;
    mismatch_count = 0;
    failure_count  = 0;
    loaded         = 1'b0;
    load_testdata();
    loaded  = 1'b1;
    pending = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    arst_n <= 1'b1;
    foreach (ops[i]) begin
      entry = ops[i];
      @(posedge clock);
      drive_op(entry);
      @(negedge clock);
      check_rsp(bus_rsp, expected_rsp(pending), pending.address);
      if (entry.op == "P") begin
        check_gpio(gpio_output, entry.expected[mcu_pkg::GPIO_WIDTH-1:0], "gpio_output");
        check_gpio(gpio_oe, entry.expected[mcu_pkg::GPIO_WIDTH +: mcu_pkg::GPIO_WIDTH],
                   "gpio_oe");
      end else if (entry.op == "I") begin
        check_irq(irq_timer, entry.expected[0]);
      end
      pending = entry;
    end
    // Drain the last access
    @(posedge clock);
    bus_req <= '0;
    @(negedge clock);
    check_rsp(bus_rsp, expected_rsp(pending), pending.address);
    report_counts();
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Ten clock periods per file line
  initial begin : watchdog
    wait (loaded === 1'b1);
    #(line_count * 10 * CLK_PERIOD);
    $display("Timeout: the test did not finish within %0d ns", line_count * 10 * CLK_PERIOD);
    report_counts();
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/mcu_props.sv */
`default_nettype none

module mcu_props (
  input wire                    clock,
  input wire                    arst_n,
  input wire mcu_pkg::bus_req_t mgr_req,
  input wire mcu_pkg::bus_rsp_t mgr_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------------------------------------------
  // Request to response timing
  // ------------------------------------------------------------------

  read_answered: assert property (@(posedge clock) disable iff (!arst_n)
    mgr_req.read_request |=> mgr_rsp.read_response)
    else $error("Read request got no response one cycle later");

  write_answered: assert property (@(posedge clock) disable iff (!arst_n)
    mgr_req.write_request |=> mgr_rsp.write_response)
    else $error("Write request got no response one cycle later");

  // Only one kind of request per cycle
  single_request: assert property (@(posedge clock) disable iff (!arst_n)
    !(mgr_req.read_request && mgr_req.write_request))
    else $error("Read and write requests high together");

  // Responses only follow a request
  read_rsp_has_req: assert property (@(posedge clock) disable iff (!arst_n)
    mgr_rsp.read_response |-> $past(mgr_req.read_request))
    else $error("Read response without a read request one cycle earlier");

  write_rsp_has_req: assert property (@(posedge clock) disable iff (!arst_n)
    mgr_rsp.write_response |-> $past(mgr_req.write_request))
    else $error("Write response without a write request one cycle earlier");

endmodule

bind system_bus mcu_props mcu_props_inst (
  .clock   (clock),
  .arst_n  (arst_n),
  .mgr_req (mgr_req),
  .mgr_rsp (mgr_rsp)
);

`default_nettype wire

/* source/mcu_subsystem.sv */
`default_nettype none

module mcu_subsystem (
  input  wire                           clock,
  input  wire                           arst_n,
  input  wire mcu_pkg::bus_req_t        bus_req,
  output wire mcu_pkg::bus_rsp_t        bus_rsp,
  output wire                           irq_timer,
  input  wire [mcu_pkg::GPIO_WIDTH-1:0] gpio_input,
  output wire [mcu_pkg::GPIO_WIDTH-1:0] gpio_output,
  output wire [mcu_pkg::GPIO_WIDTH-1:0] gpio_oe
);

  // Device slots, indexed in device_e order
  wire mcu_pkg::bus_req_t dev_req [mcu_pkg::NUM_DEVICES];
  wire mcu_pkg::bus_rsp_t dev_rsp [mcu_pkg::NUM_DEVICES];

  // ------------------------------------------------------------------
  // System bus
  // ------------------------------------------------------------------

  system_bus system_bus_inst (
    .clock   (clock),
    .arst_n  (arst_n),
    .mgr_req (bus_req),
    .mgr_rsp (bus_rsp),
    .dev_req (dev_req),
    .dev_rsp (dev_rsp)
  );

  // ------------------------------------------------------------------
  // Devices
  // ------------------------------------------------------------------

  ram ram_inst (
    .clock  (clock),
    .arst_n (arst_n),
    .req    (dev_req[mcu_pkg::DEV_RAM]),
    .rsp    (dev_rsp[mcu_pkg::DEV_RAM])
  );

  // Timer interrupt goes straight out as a level
  mtimer mtimer_inst (
    .clock  (clock),
    .arst_n (arst_n),
    .req    (dev_req[mcu_pkg::DEV_MTIMER]),
    .rsp    (dev_rsp[mcu_pkg::DEV_MTIMER]),
    .irq    (irq_timer)
  );

  gpio gpio_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .req         (dev_req[mcu_pkg::DEV_GPIO]),
    .rsp         (dev_rsp[mcu_pkg::DEV_GPIO]),
    .gpio_input  (gpio_input),
    .gpio_output (gpio_output),
    .gpio_oe     (gpio_oe)
  );

endmodule

`default_nettype wire

/* source/gpio.sv */
`default_nettype none

module gpio (
  input  wire                            clock,
  input  wire                            arst_n,
  input  wire mcu_pkg::bus_req_t         req,
  output mcu_pkg::bus_rsp_t              rsp,
  input  wire [mcu_pkg::GPIO_WIDTH-1:0]  gpio_input,
  output logic [mcu_pkg::GPIO_WIDTH-1:0] gpio_output,
  output logic [mcu_pkg::GPIO_WIDTH-1:0] gpio_oe
);

  logic [mcu_pkg::REG_OFFSET_WIDTH-1:0] offset;
  logic [mcu_pkg::GPIO_WIDTH-1:0]       in_meta;
  logic [mcu_pkg::GPIO_WIDTH-1:0]       in_sync;
  logic [31:0]                          rd_word;
  logic [31:0]                          rd_data_q;
  logic                                 rd_rsp_q;
  logic                                 wr_rsp_q;

  assign offset = req.address[mcu_pkg::REG_OFFSET_WIDTH-1:0];

  // Two-flop synchronizer on the pins
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_input;
      in_sync <= in_meta;
    end
  end

  // ------------------------------------------------------------------
  // Output and output-enable registers
  // ------------------------------------------------------------------

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      gpio_output <= '0;
      gpio_oe     <= '0;
    end else if (req.write_request && req.write_strobe[0]) begin
      if (offset == mcu_pkg::GPIO_OUT) begin
        gpio_output <= req.write_data[mcu_pkg::GPIO_WIDTH-1:0];
      end
      if (offset == mcu_pkg::GPIO_OE) begin
        gpio_oe <= req.write_data[mcu_pkg::GPIO_WIDTH-1:0];
      end
    end
  end

  // Reads zero-extended to the bus width
  always_comb begin
    case (offset)
      mcu_pkg::GPIO_IN:  rd_word = 32'(in_sync);
      mcu_pkg::GPIO_OUT: rd_word = 32'(gpio_output);
      mcu_pkg::GPIO_OE:  rd_word = 32'(gpio_oe);
      default:           rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (req.read_request) begin
      rd_data_q <= rd_word;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_rsp_q <= 1'b0;
      wr_rsp_q <= 1'b0;
    end else begin
      rd_rsp_q <= req.read_request;
      wr_rsp_q <= req.write_request;
    end
  end

  assign rsp.read_data      = rd_data_q;
  assign rsp.read_response  = rd_rsp_q;
  assign rsp.write_response = wr_rsp_q;

endmodule

`default_nettype wire

/* source/mtimer.sv */
`default_nettype none

module mtimer (
  input  wire                    clock,
  input  wire                    arst_n,
  input  wire mcu_pkg::bus_req_t req,
  output mcu_pkg::bus_rsp_t      rsp,
  output logic                   irq
);

  logic [mcu_pkg::REG_OFFSET_WIDTH-1:0] offset;
  logic [63:0]                          mtime;
  logic [63:0]                          mtimecmp;
  logic                                 enable;
  logic [31:0]                          rd_word;
  logic [31:0]                          rd_data_q;
  logic                                 rd_rsp_q;
  logic                                 wr_rsp_q;

  // Byte lanes of a 32-bit half under the strobe
  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strobe
  );
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strobe[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  assign offset = req.address[mcu_pkg::REG_OFFSET_WIDTH-1:0];

  // ------------------------------------------------------------------
  // Counter and compare registers
  // ------------------------------------------------------------------

  // A write to either half of mtime wins over the increment
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= 64'h0;
    end else if (req.write_request && offset == mcu_pkg::MTIME_LO) begin
      mtime[31:0] <= merge_bytes(mtime[31:0], req.write_data, req.write_strobe);
    end else if (req.write_request && offset == mcu_pkg::MTIME_HI) begin
      mtime[63:32] <= merge_bytes(mtime[63:32], req.write_data, req.write_strobe);
    end else if (enable) begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtimecmp <= 64'h0;
      enable   <= 1'b0;
    end else if (req.write_request) begin
      case (offset)
        mcu_pkg::MTIMECMP_LO: begin
          mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], req.write_data, req.write_strobe);
        end
        mcu_pkg::MTIMECMP_HI: begin
          mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req.write_data, req.write_strobe);
        end
        mcu_pkg::MTIMER_CTRL: begin
          if (req.write_strobe[0]) begin
            enable <= req.write_data[0];
          end
        end
        default: ;
      endcase
    end
  end

  // Interrupt level, one edge behind the compare
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= enable && (mtime >= mtimecmp);
    end
  end

  // ------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------

  always_comb begin
    case (offset)
      mcu_pkg::MTIME_LO:    rd_word = mtime[31:0];
      mcu_pkg::MTIME_HI:    rd_word = mtime[63:32];
      mcu_pkg::MTIMECMP_LO: rd_word = mtimecmp[31:0];
      mcu_pkg::MTIMECMP_HI: rd_word = mtimecmp[63:32];
      mcu_pkg::MTIMER_CTRL: rd_word = {31'h0, enable};
      default:              rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (req.read_request) begin
      rd_data_q <= rd_word;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_rsp_q <= 1'b0;
      wr_rsp_q <= 1'b0;
    end else begin
      rd_rsp_q <= req.read_request;
      wr_rsp_q <= req.write_request;
    end
  end

  assign rsp.read_data      = rd_data_q;
  assign rsp.read_response  = rd_rsp_q;
  assign rsp.write_response = wr_rsp_q;

endmodule

`default_nettype wire

/* source/ram.sv */
`default_nettype none

module ram (
  input  wire                    clock,
  input  wire                    arst_n,
  input  wire mcu_pkg::bus_req_t req,
  output mcu_pkg::bus_rsp_t      rsp
);

  logic [31:0] mem [mcu_pkg::RAM_WORDS];

  logic [mcu_pkg::RAM_INDEX_WIDTH-1:0] word_index;
  logic [31:0]                         rd_data_q;
  logic                                rd_rsp_q;
  logic                                wr_rsp_q;

  // Word bits of the offset, byte bits dropped
  assign word_index = req.address[mcu_pkg::RAM_INDEX_WIDTH+1:2];

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (req.write_request) begin
      for (int b = 0; b < 4; b++) begin
        if (req.write_strobe[b]) begin
          mem[word_index][8*b +: 8] <= req.write_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.read_request) begin
      rd_data_q <= mem[word_index];
    end
  end

  // Response pulses one cycle after the request
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rd_rsp_q <= 1'b0;
      wr_rsp_q <= 1'b0;
    end else begin
      rd_rsp_q <= req.read_request;
      wr_rsp_q <= req.write_request;
    end
  end

  assign rsp.read_data      = rd_data_q;
  assign rsp.read_response  = rd_rsp_q;
  assign rsp.write_response = wr_rsp_q;

endmodule

`default_nettype wire

/* source/system_bus.sv */
`default_nettype none

module system_bus (
  input  wire                    clock,
  input  wire                    arst_n,
  input  wire mcu_pkg::bus_req_t mgr_req,
  output mcu_pkg::bus_rsp_t      mgr_rsp,
  output mcu_pkg::bus_req_t      dev_req [mcu_pkg::NUM_DEVICES],
  input  wire mcu_pkg::bus_rsp_t dev_rsp [mcu_pkg::NUM_DEVICES]
);

  mcu_pkg::device_e dev_sel;
  mcu_pkg::device_e sel_q;
  logic             req_valid;
  logic             none_rd_q;
  logic             none_wr_q;

  // Unsigned wraparound keeps this a single compare, also for base 0
  function automatic logic in_region(
    input logic [31:0] addr,
    input logic [31:0] base,
    input logic [31:0] size
  );
    return (addr - base) < size;
  endfunction

  // ------------------------------------------------------------------
  // Address decoder
  // ------------------------------------------------------------------

  always_comb begin
    if (in_region(mgr_req.address, mcu_pkg::RAM_BASE, mcu_pkg::RAM_SIZE)) begin
      dev_sel = mcu_pkg::DEV_RAM;
    end else if (in_region(mgr_req.address, mcu_pkg::MTIMER_BASE, mcu_pkg::MTIMER_SIZE)) begin
      dev_sel = mcu_pkg::DEV_MTIMER;
    end else if (in_region(mgr_req.address, mcu_pkg::GPIO_BASE, mcu_pkg::GPIO_SIZE)) begin
      dev_sel = mcu_pkg::DEV_GPIO;
    end else begin
      dev_sel = mcu_pkg::DEV_NONE;
    end
  end

  assign req_valid = mgr_req.read_request | mgr_req.write_request;

  // Request fan-out, only the selected slot sees the request bits
  always_comb begin
    for (int i = 0; i < mcu_pkg::NUM_DEVICES; i++) begin
      dev_req[i] = mgr_req;
      if (dev_sel != mcu_pkg::device_e'(i)) begin
        dev_req[i].read_request  = 1'b0;
        dev_req[i].write_request = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // Response routing
  // ------------------------------------------------------------------

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      sel_q <= mcu_pkg::DEV_NONE;
    end else if (req_valid) begin
      sel_q <= dev_sel;
    end
  end

  // Local answer for unmapped accesses
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      none_rd_q <= 1'b0;
      none_wr_q <= 1'b0;
    end else begin
      none_rd_q <= mgr_req.read_request  && (dev_sel == mcu_pkg::DEV_NONE);
      none_wr_q <= mgr_req.write_request && (dev_sel == mcu_pkg::DEV_NONE);
    end
  end

  always_comb begin
    mgr_rsp.read_data      = 32'h0;
    mgr_rsp.read_response  = none_rd_q;
    mgr_rsp.write_response = none_wr_q;
    for (int i = 0; i < mcu_pkg::NUM_DEVICES; i++) begin
      if (sel_q == mcu_pkg::device_e'(i)) begin
        mgr_rsp = dev_rsp[i];
      end
    end
  end

endmodule

`default_nettype wire

/* source/mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

  // ------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------

  localparam int unsigned NUM_DEVICES = 3;

  localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
  localparam logic [31:0] RAM_SIZE    = 32'd1024;

  localparam logic [31:0] MTIMER_BASE = 32'h8001_0000;
  localparam logic [31:0] MTIMER_SIZE = 32'd32;

  localparam logic [31:0] GPIO_BASE   = 32'h8002_0000;
  localparam logic [31:0] GPIO_SIZE   = 32'd32;

  // Derived sizes
  localparam int unsigned RAM_WORDS        = RAM_SIZE / 4;
  localparam int unsigned RAM_INDEX_WIDTH  = $clog2(RAM_WORDS);
  localparam int unsigned GPIO_WIDTH       = 8;
  localparam int unsigned REG_OFFSET_WIDTH = 5;

  // ------------------------------------------------------------------
  // Register offsets
  // ------------------------------------------------------------------

  // Machine timer
  localparam logic [REG_OFFSET_WIDTH-1:0] MTIME_LO    = 5'h00;
  localparam logic [REG_OFFSET_WIDTH-1:0] MTIME_HI    = 5'h04;
  localparam logic [REG_OFFSET_WIDTH-1:0] MTIMECMP_LO = 5'h08;
  localparam logic [REG_OFFSET_WIDTH-1:0] MTIMECMP_HI = 5'h0C;
  localparam logic [REG_OFFSET_WIDTH-1:0] MTIMER_CTRL = 5'h10;

  // GPIO
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_IN  = 5'h00;
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_OUT = 5'h04;
  localparam logic [REG_OFFSET_WIDTH-1:0] GPIO_OE  = 5'h08;

  // ------------------------------------------------------------------
  // Bus types
  // ------------------------------------------------------------------

  typedef struct packed {
    logic [31:0] address;
    logic [31:0] write_data;
    logic [3:0]  write_strobe;
    logic        read_request;
    logic        write_request;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] read_data;
    logic        read_response;
    logic        write_response;
  } bus_rsp_t;

  // Device slot order, DEV_NONE for unmapped addresses
  typedef enum logic [1:0] {
    DEV_RAM    = 2'd0,
    DEV_MTIMER = 2'd1,
    DEV_GPIO   = 2'd2,
    DEV_NONE   = 2'd3
  } device_e;

endpackage

`default_nettype wire
